/* include/stats_defs.svh */
`ifndef STATS_DEFS_SVH
`define STATS_DEFS_SVH

// sample, counter and sum widths
`define STATS_DATA_WIDTH 8
`define STATS_CNT_WIDTH 16
`define STATS_SUM_WIDTH 24

// bits compared per min/max pipeline stage, so 8/4 gives two stages
`define STATS_CHUNK_BITS 4

// register byte offsets on the AXI4-Lite port
`define STATS_REG_CTRL 32'h0000_0000
`define STATS_REG_MIN 32'h0000_0004
`define STATS_REG_MAX 32'h0000_0008
`define STATS_REG_COUNT 32'h0000_000C
`define STATS_REG_SUM 32'h0000_0010

`endif

/* source/stats_pkg.sv */
`include "stats_defs.svh"

package stats_pkg;

  // one sample slot on the input stream, valid for a single cycle
  typedef struct packed {
    logic                         valid;
    logic [`STATS_DATA_WIDTH-1:0] val;
  } sample_t;

  // snapshot of everything software can read back
  typedef struct packed {
    logic [`STATS_DATA_WIDTH-1:0] min;
    logic [`STATS_DATA_WIDTH-1:0] max;
    logic [`STATS_CNT_WIDTH-1:0]  count;
    logic [`STATS_SUM_WIDTH-1:0]  sum;
  } result_t;

endpackage

/* source/csr_pkg.sv */
package csr_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // fields driven by the bus master
  typedef struct packed {
    logic                  awvalid;
    logic [addr_width-1:0] awaddr;
    logic                  wvalid;
    logic [data_width-1:0] wdata;
    logic                  bready;
    logic                  arvalid;
    logic [addr_width-1:0] araddr;
    logic                  rready;
  } axil_req_t;

  // fields driven by the register slave
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    resp_t                 bresp;
    logic                  arready;
    logic                  rvalid;
    logic [data_width-1:0] rdata;
    resp_t                 rresp;
  } axil_rsp_t;

endpackage

/* source/stats_extreme.sv */
`timescale 1ns/1ps
`include "stats_defs.svh"

module stats_extreme #(
  parameter bit FIND_MAX   = 1'b0,
  parameter int CHUNK_BITS = `STATS_CHUNK_BITS
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clear,
  input  stats_pkg::sample_t           sample,
  output logic [`STATS_DATA_WIDTH-1:0] extreme
);

  localparam int W = `STATS_DATA_WIDTH;
  localparam int STAGES = W / CHUNK_BITS;
  localparam logic [W-1:0] INIT = {W{~FIND_MAX}}; // all ones for min, zero for max

  typedef struct packed {
    logic         valid;
    logic [W-1:0] val;
    logic         better; // sample already beats the stored extreme
    logic         worse;  // sample already lost, nothing more to write
    logic [W-1:0] acc;    // extreme as it stands after this sample, filled chunk by chunk
  } stage_t;

  stage_t                pipe [STAGES+1];
  logic [CHUNK_BITS-1:0] chunk_q [STAGES];

  // the first stage sees the raw sample with nothing decided yet
  assign pipe[0] = '{
    valid:  sample.valid,
    val:    sample.val,
    better: 1'b0,
    worse:  1'b0,
    acc:    '0
  };

  for (genvar k = 0; k < STAGES; k++) begin : g_stage
    localparam int LSB = W - (k + 1) * CHUNK_BITS; // stage 0 owns the top chunk

    logic [CHUNK_BITS-1:0] s_chunk;
    logic                  chunk_better;
    logic                  chunk_worse;
    logic                  take;

    assign s_chunk      = pipe[k].val[LSB +: CHUNK_BITS];
    assign chunk_better = FIND_MAX ? (s_chunk > chunk_q[k]) : (s_chunk < chunk_q[k]);
    assign chunk_worse  = FIND_MAX ? (s_chunk < chunk_q[k]) : (s_chunk > chunk_q[k]);
    assign take         = pipe[k].better | (~pipe[k].worse & chunk_better);

    // the predecessor passed this stage one cycle earlier, so chunk_q is already current
    always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
        chunk_q[k] <= INIT[LSB +: CHUNK_BITS];
      end else if (pipe[k].valid && take) begin
        chunk_q[k] <= s_chunk;
      end
    end

    always_ff @(posedge clk) begin
      pipe[k+1].val    <= pipe[k].val;
      pipe[k+1].better <= take;
      pipe[k+1].worse  <= pipe[k].worse | (~pipe[k].better & chunk_worse);
      pipe[k+1].acc    <= pipe[k].acc;
      pipe[k+1].acc[LSB +: CHUNK_BITS] <= take ? s_chunk : chunk_q[k];
      if (!rst_n || clear) begin
        pipe[k+1].valid <= 1'b0; // in-flight samples are dropped on clear
      end else begin
        pipe[k+1].valid <= pipe[k].valid;
      end
    end
  end

  // chunks travel with the sample, so the output never mixes two samples
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      extreme <= INIT;
    end else if (pipe[STAGES].valid) begin
      extreme <= pipe[STAGES].acc;
    end
  end

endmodule

/* source/stats_accum.sv */
`timescale 1ns/1ps
`include "stats_defs.svh"

module stats_accum (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clear,
  input  stats_pkg::sample_t          sample,
  output logic [`STATS_CNT_WIDTH-1:0] count,
  output logic [`STATS_SUM_WIDTH-1:0] sum
);

  localparam int DW = `STATS_DATA_WIDTH;
  localparam int SW = `STATS_SUM_WIDTH;

  logic [SW:0] sum_ext;

  // one extra bit catches the carry out of the sum
  assign sum_ext = {1'b0, sum} + {{(SW + 1 - DW){1'b0}}, sample.val};

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      count <= '0;
    end else if (sample.valid && (count != '1)) begin
      count <= count + 1'b1; // stops at all ones
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      sum <= '0;
    end else if (sample.valid) begin
      if (sum_ext[SW]) begin
        sum <= '1;
      end else begin
        sum <= sum_ext[SW-1:0];
      end
    end
  end

endmodule

/* source/stats_csr.sv */
`timescale 1ns/1ps
`include "stats_defs.svh"

module stats_csr (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::axil_req_t bus_req,
  output csr_pkg::axil_rsp_t bus_rsp,
  input  stats_pkg::result_t results,
  output logic               enable,
  output logic               clear
);

  localparam int AW = csr_pkg::addr_width;
  localparam int DW = csr_pkg::data_width;

  logic           aw_full;
  logic [AW-1:0]  aw_addr;
  logic           w_full;
  logic [DW-1:0]  w_data;
  logic           bvalid;
  csr_pkg::resp_t bresp;
  logic           rvalid;
  logic [DW-1:0]  rdata;
  csr_pkg::resp_t rresp;

  logic           awready;
  logic           wready;
  logic           arready;
  logic           aw_hs;
  logic           w_hs;
  logic           ar_hs;
  logic           wr_go;
  logic           wr_ctrl;
  logic [DW-1:0]  rd_data;
  csr_pkg::resp_t rd_resp;

  // a pending write response holds off both write channels
  assign awready = ~aw_full & ~bvalid;
  assign wready  = ~w_full & ~bvalid;
  assign arready = ~rvalid;

  assign aw_hs = bus_req.awvalid & awready;
  assign w_hs  = bus_req.wvalid & wready;
  assign ar_hs = bus_req.arvalid & arready;

  assign wr_go   = aw_full & w_full; // both halves in hand, commit on the next edge
  assign wr_ctrl = (aw_addr == `STATS_REG_CTRL);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bvalid  <= 1'b0;
      enable  <= 1'b0;
      clear   <= 1'b0;
    end else begin
      clear <= 1'b0;
      if (aw_hs) begin
        aw_full <= 1'b1;
      end
      if (w_hs) begin
        w_full <= 1'b1;
      end
      if (wr_go) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
        bvalid  <= 1'b1;
        if (wr_ctrl) begin
          enable <= w_data[0];
          clear  <= w_data[1]; // high only in the cycle bvalid rises
        end
      end else if (bvalid && bus_req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_addr <= bus_req.awaddr;
    end
    if (w_hs) begin
      w_data <= bus_req.wdata;
    end
    if (wr_go) begin
      bresp <= wr_ctrl ? csr_pkg::resp_okay : csr_pkg::resp_slverr;
    end
  end

  always_comb begin
    rd_data = '0;
    rd_resp = csr_pkg::resp_okay;
    case (bus_req.araddr)
      `STATS_REG_CTRL:  rd_data = {{(DW - 1){1'b0}}, enable}; // clear bit reads zero
      `STATS_REG_MIN:   rd_data = DW'(results.min);
      `STATS_REG_MAX:   rd_data = DW'(results.max);
      `STATS_REG_COUNT: rd_data = DW'(results.count);
      `STATS_REG_SUM:   rd_data = DW'(results.sum);
      default:          rd_resp = csr_pkg::resp_slverr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (ar_hs) begin
      rvalid <= 1'b1;
    end else if (bus_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  // captured once per read so the data stays put while rvalid waits
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  assign bus_rsp.awready = awready;
  assign bus_rsp.wready  = wready;
  assign bus_rsp.bvalid  = bvalid;
  assign bus_rsp.bresp   = bresp;
  assign bus_rsp.arready = arready;
  assign bus_rsp.rvalid  = rvalid;
  assign bus_rsp.rdata   = rdata;
  assign bus_rsp.rresp   = rresp;

endmodule

/* source/stats_top.sv */
`timescale 1ns/1ps
`include "stats_defs.svh"

module stats_top (
  input  logic               clk,
  input  logic               rst_n,
  input  stats_pkg::sample_t sample,
  input  csr_pkg::axil_req_t bus_req,
  output csr_pkg::axil_rsp_t bus_rsp
);

  logic                         enable;
  logic                         clear;
  stats_pkg::sample_t           accepted;
  stats_pkg::result_t           results;
  logic [`STATS_DATA_WIDTH-1:0] min_val;
  logic [`STATS_DATA_WIDTH-1:0] max_val;
  logic [`STATS_CNT_WIDTH-1:0]  count;
  logic [`STATS_SUM_WIDTH-1:0]  sum;

  // acceptance is decided here once so all three blocks agree on every sample
  assign accepted.valid = sample.valid & enable;
  assign accepted.val   = sample.val;

  assign results = '{min: min_val, max: max_val, count: count, sum: sum};

  stats_extreme #(
    .FIND_MAX  (1'b0),
    .CHUNK_BITS(`STATS_CHUNK_BITS)
  ) min_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (clear),
    .sample (accepted),
    .extreme(min_val)
  );

  stats_extreme #(
    .FIND_MAX  (1'b1),
    .CHUNK_BITS(`STATS_CHUNK_BITS)
  ) max_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (clear),
    .sample (accepted),
    .extreme(max_val)
  );

  stats_accum accum (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (clear),
    .sample(accepted),
    .count (count),
    .sum   (sum)
  );

  stats_csr csr (
    .clk    (clk),
    .rst_n  (rst_n),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp),
    .results(results),
    .enable (enable),
    .clear  (clear)
  );

endmodule

/* verification/stats_checker.sv */
`timescale 1ns/1ps

module stats_checker (
  input logic               clk,
  input logic               rst_n,
  input csr_pkg::axil_req_t bus_req,
  input csr_pkg::axil_rsp_t bus_rsp,
  input stats_pkg::result_t results,
  input logic               clear
);

  int unsigned fail_count = 0; // read by the testbench at the end of the run

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid && $stable(bus_rsp.bresp))
  else begin
    $error("bvalid or bresp changed before bready");
    fail_count++;
  end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rsp.rvalid && !bus_req.rready
      |=> bus_rsp.rvalid && $stable(bus_rsp.rdata) && $stable(bus_rsp.rresp))
  else begin
    $error("rvalid, rdata or rresp changed before rready");
    fail_count++;
  end

  reset_idle: assert property (@(posedge clk)
    !rst_n |=> !bus_rsp.bvalid && !bus_rsp.rvalid
               && bus_rsp.awready && bus_rsp.wready && bus_rsp.arready)
  else begin
    $error("slave handshake outputs not idle after a reset edge");
    fail_count++;
  end

  // min and max lag the count by two edges, so the count must have been up for three samples
  min_le_max: assert property (@(posedge clk) disable iff (!rst_n)
    (results.count != 0) && ($past(results.count) != 0) && ($past(results.count, 2) != 0)
      |-> results.min <= results.max)
  else begin
    $error("minimum above maximum while samples are counted");
    fail_count++;
  end

  count_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
    !clear |=> results.count >= $past(results.count))
  else begin
    $error("count went down without a clear");
    fail_count++;
  end

endmodule

bind stats_top stats_checker chk (
  .clk    (clk),
  .rst_n  (rst_n),
  .bus_req(bus_req),
  .bus_rsp(bus_rsp),
  .results(results),
  .clear  (clear)
);

/* verification/stats_tb.sv */
`timescale 1ns/1ps
`include "stats_defs.svh"

module stats_tb;

  localparam int timeout_cycles = 100;
  localparam int stage_count = `STATS_DATA_WIDTH / `STATS_CHUNK_BITS;
  localparam logic [`STATS_CNT_WIDTH-1:0] cnt_max = '1;
  localparam logic [`STATS_SUM_WIDTH:0] sum_max = {1'b0, {`STATS_SUM_WIDTH{1'b1}}};

  logic               clk = 1'b0;
  logic               rst_n;
  stats_pkg::sample_t sample;
  csr_pkg::axil_req_t bus_req;
  csr_pkg::axil_rsp_t bus_rsp;

  integer seed = 32'h8e6d;
  int     errors = 0;
  int     timeouts = 0;

  bit                           model_enable;
  logic [`STATS_DATA_WIDTH-1:0] model_min;
  logic [`STATS_DATA_WIDTH-1:0] model_max;
  logic [`STATS_CNT_WIDTH-1:0]  model_count;
  logic [`STATS_SUM_WIDTH-1:0]  model_sum;

  stats_top UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (sample),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp)
  );

  always #5 clk = ~clk;

  function automatic void model_clear();
    model_min   = '1;
    model_max   = '0;
    model_count = '0;
    model_sum   = '0;
  endfunction

  function automatic void model_accept(input logic [`STATS_DATA_WIDTH-1:0] v);
    logic [`STATS_SUM_WIDTH:0] wide;
    wide = {1'b0, model_sum} + v;
    if (v < model_min) begin
      model_min = v;
    end
    if (v > model_max) begin
      model_max = v;
    end
    if (model_count != cnt_max) begin
      model_count = model_count + 1'b1;
    end
    model_sum = (wide > sum_max) ? sum_max[`STATS_SUM_WIDTH-1:0] : wide[`STATS_SUM_WIDTH-1:0];
  endfunction

  function automatic logic rsp_flag(input string name);
    case (name)
      "awready": return bus_rsp.awready;
      "wready":  return bus_rsp.wready;
      "arready": return bus_rsp.arready;
      "bvalid":  return bus_rsp.bvalid;
      default:   return bus_rsp.rvalid;
    endcase
  endfunction

  // returns at a falling edge with the flag high, so the next rising edge completes the handshake
  task automatic wait_for(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!rsp_flag(name) && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!rsp_flag(name)) begin
      timeouts++;
      $display("timeout at %0t: %s stayed low for %0d cycles", $time, name, timeout_cycles);
    end
  endtask

  task automatic send_aw(input logic [31:0] addr);
    bus_req.awvalid <= 1'b1;
    bus_req.awaddr  <= addr;
    wait_for("awready");
    @(posedge clk);
    bus_req.awvalid <= 1'b0;
  endtask

  task automatic send_w(input logic [31:0] data);
    bus_req.wvalid <= 1'b1;
    bus_req.wdata  <= data;
    wait_for("wready");
    @(posedge clk);
    bus_req.wvalid <= 1'b0;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input bit aw_first, output logic [1:0] resp);
    @(posedge clk);
    if (aw_first) begin
      send_aw(addr);
      send_w(data);
    end else begin
      send_w(data);
      send_aw(addr);
    end
    wait_for("bvalid");
    @(posedge clk);
    bus_req.bready <= 1'b1; // one cycle late so the slave has to hold the response
    @(negedge clk);
    resp = bus_rsp.bresp;
    @(posedge clk);
    bus_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk);
    bus_req.arvalid <= 1'b1;
    bus_req.araddr  <= addr;
    wait_for("arready");
    @(posedge clk);
    bus_req.arvalid <= 1'b0;
    wait_for("rvalid");
    @(posedge clk);
    bus_req.rready <= 1'b1;
    @(negedge clk);
    data = bus_rsp.rdata;
    resp = bus_rsp.rresp;
    @(posedge clk);
    bus_req.rready <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected)
    else begin
      errors++;
      $display("[FAIL] %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_value({name, " rresp"}, resp, exp_resp);
    check_value(name, data, exp_data);
  endtask

  task automatic write_check(input string name, input logic [31:0] addr, input logic [31:0] data,
                             input bit aw_first, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(addr, data, aw_first, resp);
    check_value({name, " bresp"}, resp, exp_resp);
  endtask

  task automatic write_ctrl(input logic [31:0] data, input bit aw_first);
    write_check("CTRL", `STATS_REG_CTRL, data, aw_first, csr_pkg::resp_okay);
    model_enable = data[0];
    if (data[1]) begin
      model_clear();
    end
  endtask

  task automatic check_results();
    read_check("MIN", `STATS_REG_MIN, model_min, csr_pkg::resp_okay);
    read_check("MAX", `STATS_REG_MAX, model_max, csr_pkg::resp_okay);
    read_check("COUNT", `STATS_REG_COUNT, model_count, csr_pkg::resp_okay);
    read_check("SUM", `STATS_REG_SUM, model_sum, csr_pkg::resp_okay);
  endtask

  // back-to-back samples, one per clock, random or a fixed value
  task automatic drive_samples(input int n, input bit use_random,
                               input logic [`STATS_DATA_WIDTH-1:0] fixed);
    logic [`STATS_DATA_WIDTH-1:0] v;
    int                           i;
    for (i = 0; i < n; i++) begin
      v = use_random ? `STATS_DATA_WIDTH'($random(seed)) : fixed;
      @(posedge clk);
      sample <= '{valid: 1'b1, val: v};
      if (model_enable) begin
        model_accept(v);
      end
    end
    @(posedge clk);
    sample <= '{valid: 1'b0, val: '0};
    repeat (stage_count + 1) @(posedge clk); // let the min/max pipeline drain
  endtask

  initial begin
    rst_n        = 1'b0;
    sample       = '0;
    bus_req      = '0;
    model_enable = 1'b0;
    model_clear();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    read_check("CTRL", `STATS_REG_CTRL, 32'h0, csr_pkg::resp_okay);
    check_results();
    drive_samples(8, 1'b1, '0); // collection still off
    check_results();

    write_ctrl(32'h1, 1'b1);
    drive_samples(64, 1'b1, '0);
    check_results();

    write_ctrl(32'h3, 1'b0); // clear with enable kept on
    read_check("CTRL", `STATS_REG_CTRL, 32'h1, csr_pkg::resp_okay);
    check_results();

    drive_samples(66000, 1'b0, '1); // enough 0xff samples to overflow 24 bits
    read_check("SUM", `STATS_REG_SUM, 32'h00ff_ffff, csr_pkg::resp_okay);
    check_results();

    write_check("unmapped write", 32'h0000_0020, 32'h0, 1'b1, csr_pkg::resp_slverr);
    write_check("MIN write", `STATS_REG_MIN, 32'h0, 1'b0, csr_pkg::resp_slverr);
    read_check("unmapped read", 32'h0000_0020, 32'h0, csr_pkg::resp_slverr);
    read_check("CTRL", `STATS_REG_CTRL, 32'h1, csr_pkg::resp_okay);

    write_ctrl(32'h0, 1'b0);
    read_check("CTRL", `STATS_REG_CTRL, 32'h0, csr_pkg::resp_okay);
    write_ctrl(32'h1, 1'b1);
    read_check("CTRL", `STATS_REG_CTRL, 32'h1, csr_pkg::resp_okay);

    $display("errors: %0d failed checks, %0d timeouts, %0d checker assertion failures",
             errors, timeouts, UUT.chk.fail_count);
    if (errors == 0 && timeouts == 0 && UUT.chk.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* stats_top.f */
+incdir+include
source/stats_pkg.sv
source/csr_pkg.sv
source/stats_extreme.sv
source/stats_accum.sv
source/stats_csr.sv
source/stats_top.sv
verification/stats_checker.sv
verification/stats_tb.sv

/* Bender.yml */
package:
  name: stats_top

export_include_dirs:
  - include

sources:
  - files:
      - source/stats_pkg.sv
      - source/csr_pkg.sv
      - source/stats_extreme.sv
      - source/stats_accum.sv
      - source/stats_csr.sv
      - source/stats_top.sv
  - target: test
    files:
      - verification/stats_checker.sv
      - verification/stats_tb.sv
